// ==== bfly_engine.f ====
source/bfly_pkg.sv
source/bfly_s2p.sv
source/bfly_row_ram.sv
source/bfly_sequencer.sv
source/bfly_unit.sv
source/bfly_p2s.sv
source/bfly_engine.sv
verification/bfly_engine_assert.sv
verification/tb_bfly_engine.sv

// ==== run_sim.sh ====
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_bfly_engine -f bfly_engine.f -o sim_bfly_engine

./obj_dir/sim_bfly_engine 2>&1 | tee sim.log

if grep -qx "test passed" sim.log; then
  echo "Simulation PASS"
else
  echo "Simulation FAIL"
  exit 1
fi

// ==== source/bfly_engine.sv ====
`timescale 1ns/1ps

module bfly_engine (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [7:0]                          length,
  input  logic [bfly_pkg::coef_bus_width-1:0] butterfly_coef,
  input  logic                                up_vld,
  input  logic [bfly_pkg::data_width-1:0]     up_dat,
  output logic                                up_rdy,
  output logic                                butterfly_start,
  output logic                                dn_serial_vld,
  output logic [bfly_pkg::data_width-1:0]     dn_serial_dat,
  input  logic                                dn_serial_rdy
);

  logic                                row_vld;
  bfly_pkg::row_t                      row_dat;       // From s2p
  logic                                wr_en;
  logic [bfly_pkg::row_addr_width-1:0] wr_addr;
  logic                                wr_from_bfly;
  logic                                rd_en;
  logic [bfly_pkg::row_addr_width-1:0] rd_addr;
  logic                                rd_vld;
  bfly_pkg::row_t                      rd_dat;        // RAM out, to units and p2s
  wire  bfly_pkg::row_t                bfly_row;      // Unit results, one pair each
  logic [bfly_pkg::num_units-1:0]      unit_vld;
  logic                                to_p2s;
  logic                                bfly_go;
  logic                                row_free;

  ////////////////////
  // Load and control
  ////////////////////
  bfly_s2p i_s2p (
    .clk     (clk),
    .rst_n   (rst_n),
    .up_vld  (up_vld),
    .up_dat  (up_dat),
    .up_rdy  (up_rdy),
    .row_vld (row_vld),
    .row_dat (row_dat)
  );

  bfly_sequencer i_seq (
    .clk             (clk),
    .rst_n           (rst_n),
    .length          (length),
    .up_vld          (up_vld),
    .row_vld         (row_vld),
    .bfly_vld        (unit_vld[0]),  // Unit 0 times the write-back
    .row_free        (row_free),
    .up_rdy          (up_rdy),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_from_bfly    (wr_from_bfly),
    .rd_en           (rd_en),
    .rd_addr         (rd_addr),
    .to_p2s          (to_p2s),
    .bfly_go         (bfly_go),
    .butterfly_start (butterfly_start)
  );

  bfly_row_ram i_ram (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_from_bfly (wr_from_bfly),
    .load_row     (row_dat),
    .bfly_row     (bfly_row),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .rd_vld       (rd_vld),
    .rd_dat       (rd_dat)
  );

  ////////////////////
  // Butterfly array
  ////////////////////
  for (genvar k = 0; k < bfly_pkg::num_units; k++) begin : g_unit
    bfly_unit i_unit (
      .clk        (clk),
      .rst_n      (rst_n),
      .bfly_go    (bfly_go),
      .coef_set   (butterfly_coef[k*bfly_pkg::coef_set_width +: bfly_pkg::coef_set_width]),
      .in_vld     (rd_vld),
      .in_first   (rd_dat.pair[k][0]),    // Lane 2k
      .in_second  (rd_dat.pair[k][1]),    // Lane 2k+1
      .out_vld    (unit_vld[k]),
      .out_first  (bfly_row.pair[k][0]),
      .out_second (bfly_row.pair[k][1])
    );
  end

  // Readout rows only
  bfly_p2s i_p2s (
    .clk           (clk),
    .rst_n         (rst_n),
    .up_vld        (rd_vld & to_p2s),
    .up_dat        (rd_dat),
    .row_free      (row_free),
    .dn_serial_vld (dn_serial_vld),
    .dn_serial_dat (dn_serial_dat),
    .dn_serial_rdy (dn_serial_rdy)
  );

endmodule

// ==== source/bfly_p2s.sv ====
`timescale 1ns/1ps

module bfly_p2s (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            up_vld,
  input  bfly_pkg::row_t                  up_dat,
  output logic                            row_free,
  output logic                            dn_serial_vld,
  output logic [bfly_pkg::data_width-1:0] dn_serial_dat,
  input  logic                            dn_serial_rdy
);

  bfly_pkg::row_t                      buf_q;   // Row being emitted
  logic                                full_q;
  logic [bfly_pkg::lane_idx_width-1:0] lane_q;  // Lane on the output
  logic                                take;
  logic                                last_out;

  assign take     = full_q & dn_serial_rdy;
  assign last_out = take & (&lane_q);     // Lane 7 leaving
  assign row_free = ~full_q | last_out;

  always_ff @(posedge clk) begin
    if (up_vld) begin
      buf_q <= up_dat;
    end
  end

  // Sequencer only sends a row when row_free, so no overwrite of a live row
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
      lane_q <= '0;
    end else if (up_vld) begin
      full_q <= 1'b1;
      lane_q <= '0;
    end else if (take) begin
      lane_q <= lane_q + 1'b1;
      if (last_out) begin
        full_q <= 1'b0;
      end
    end
  end

  // Held steady while rdy is low
  assign dn_serial_vld = full_q;
  assign dn_serial_dat = buf_q.lane[lane_q];

endmodule

// ==== source/bfly_pkg.sv ====
package bfly_pkg;

  ////////////////////
  // Sizes
  ////////////////////
  localparam int data_width     = 16;                    // One real sample
  localparam int num_lanes      = 8;                     // Samples per RAM row
  localparam int num_units      = num_lanes / 2;         // One unit per lane pair
  localparam int row_depth      = 16;                    // Rows in RAM, 128 samples max
  localparam int row_addr_width = $clog2(row_depth);
  localparam int lane_idx_width = $clog2(num_lanes);

  ////////////////////
  // Fixed point and pipeline
  ////////////////////
  localparam int coef_frac_bits = 14;                    // Q2.14 coefficients
  localparam int coef_set_width = 4 * data_width;        // W4..W1, W1 lowest
  localparam int coef_bus_width = num_units * coef_set_width;
  localparam int latency_mul    = 2;
  localparam int latency_add    = 1;
  localparam int bfly_latency   = latency_mul + latency_add;

  // Sequencer phases
  localparam logic [1:0] st_load    = 2'd0;
  localparam logic [1:0] st_compute = 2'd1;
  localparam logic [1:0] st_drain   = 2'd2;
  localparam logic [1:0] st_readout = 2'd3;

  // One RAM row, seen as lanes by the memory path
  // and as first/second pairs by the butterfly units
  typedef union packed {
    logic [num_lanes-1:0][data_width-1:0]      lane;
    logic [num_units-1:0][1:0][data_width-1:0] pair;  // [k][0] = lane 2k
  } row_t;

endpackage

// ==== source/bfly_row_ram.sv ====
`timescale 1ns/1ps

module bfly_row_ram (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                wr_en,
  input  logic [bfly_pkg::row_addr_width-1:0] wr_addr,
  input  logic                                wr_from_bfly,  // 1: butterfly result
  input  bfly_pkg::row_t                      load_row,
  input  bfly_pkg::row_t                      bfly_row,
  input  logic                                rd_en,
  input  logic [bfly_pkg::row_addr_width-1:0] rd_addr,
  output logic                                rd_vld,
  output bfly_pkg::row_t                      rd_dat
);

  bfly_pkg::row_t mem [bfly_pkg::row_depth];

  // Simple dual port, write and read may hit different rows in one cycle
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_from_bfly ? bfly_row : load_row;
    end
    if (rd_en) begin
      rd_dat <= mem[rd_addr];  // Registered read
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= rd_en;  // Data one cycle behind rd_en
    end
  end

endmodule

// ==== source/bfly_s2p.sv ====
`timescale 1ns/1ps

module bfly_s2p (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            up_vld,
  input  logic [bfly_pkg::data_width-1:0] up_dat,
  input  logic                            up_rdy,   // Owned by the sequencer
  output logic                            row_vld,
  output bfly_pkg::row_t                  row_dat
);

  logic [bfly_pkg::lane_idx_width-1:0] lane_q;  // Next lane to fill
  bfly_pkg::row_t                      row_q;   // Row under assembly
  logic                                accept;

  assign accept = up_vld & up_rdy;

  // Steer each accepted sample into its lane
  always_ff @(posedge clk) begin
    if (accept) begin
      row_q.lane[lane_q] <= up_dat;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_q  <= '0;
      row_vld <= 1'b0;
    end else begin
      row_vld <= accept & (&lane_q);  // Eighth sample just went in
      if (accept) begin
        lane_q <= lane_q + 1'b1;      // Wraps to lane 0 for next row
      end
    end
  end

  // Full row is presented during the row_vld cycle
  // and written by the RAM on that edge
  assign row_dat = row_q;

endmodule

// ==== source/bfly_sequencer.sv ====
`timescale 1ns/1ps

module bfly_sequencer (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [7:0]                          length,
  input  logic                                up_vld,
  input  logic                                row_vld,
  input  logic                                bfly_vld,    // Unit 0 out_vld
  input  logic                                row_free,    // p2s can take a row
  output logic                                up_rdy,
  output logic                                wr_en,
  output logic [bfly_pkg::row_addr_width-1:0] wr_addr,
  output logic                                wr_from_bfly,
  output logic                                rd_en,
  output logic [bfly_pkg::row_addr_width-1:0] rd_addr,
  output logic                                to_p2s,
  output logic                                bfly_go,
  output logic                                butterfly_start
);

  logic [1:0]                          state;
  logic [7:0]                          len_q;      // Block length of this run
  logic [7:0]                          smp_cnt;    // Accepted samples
  logic                                load_done;  // Last sample taken
  logic [bfly_pkg::row_addr_width-1:0] ld_cnt;     // Load row address
  logic [bfly_pkg::row_addr_width:0]   rd_cnt;     // Compute and readout reads
  logic [bfly_pkg::row_addr_width:0]   wb_cnt;     // Write-backs done
  logic                                rd_pend;    // Readout read in flight
  logic [bfly_pkg::row_addr_width-1:0] wa_pipe [bfly_pkg::bfly_latency+1];
  logic [7:0]                          len_cur;
  logic [bfly_pkg::row_addr_width:0]   rows_m1;
  logic                                accept;
  logic                                last_smp;
  logic                                wr_bfly;
  logic                                ro_issue;
  logic                                ro_done;
  logic                                cmp_last;
  logic                                wb_last;

  ////////////////////
  // Load side
  ////////////////////
  assign accept   = up_vld & up_rdy;
  assign len_cur  = (smp_cnt == 8'd0) ? length : len_q;  // Length sampled on first
  assign last_smp = accept & (smp_cnt == len_cur - 8'd1);
  assign rows_m1  = len_q[7:bfly_pkg::lane_idx_width] - (bfly_pkg::row_addr_width+1)'(1);
  assign up_rdy   = (state == bfly_pkg::st_load) & ~load_done;

  ////////////////////
  // RAM controls
  ////////////////////
  assign wr_bfly      = bfly_vld & ((state == bfly_pkg::st_compute) |
                                    (state == bfly_pkg::st_drain));  // Ignore readout rows
  assign wr_en        = (row_vld & (state == bfly_pkg::st_load)) | wr_bfly;
  assign wr_from_bfly = wr_bfly;
  assign wr_addr      = wr_bfly ? wa_pipe[bfly_pkg::bfly_latency] : ld_cnt;

  // Readout paced by row_free, one read in flight at most
  assign ro_issue = (state == bfly_pkg::st_readout) & row_free & ~rd_pend &
                    (rd_cnt <= rows_m1);
  assign ro_done  = (state == bfly_pkg::st_readout) & row_free & ~rd_pend &
                    (rd_cnt > rows_m1);  // Last lane leaving or buffer empty
  assign rd_en    = (state == bfly_pkg::st_compute) | ro_issue;
  assign rd_addr  = rd_cnt[bfly_pkg::row_addr_width-1:0];
  assign to_p2s   = state == bfly_pkg::st_readout;
  assign bfly_go  = (state == bfly_pkg::st_compute) & (rd_cnt == '0);  // First compute cycle
  assign cmp_last = (state == bfly_pkg::st_compute) & (rd_cnt == rows_m1);
  assign wb_last  = wr_bfly & (wb_cnt == rows_m1);

  // Write address follows its row through RAM read and the units
  always_ff @(posedge clk) begin
    wa_pipe[0] <= rd_addr;
    for (int s = 1; s <= bfly_pkg::bfly_latency; s++) begin
      wa_pipe[s] <= wa_pipe[s-1];
    end
  end

  ////////////////////
  // Phase FSM
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state           <= bfly_pkg::st_load;
      len_q           <= '0;
      smp_cnt         <= '0;
      load_done       <= 1'b0;
      ld_cnt          <= '0;
      rd_cnt          <= '0;
      wb_cnt          <= '0;
      rd_pend         <= 1'b0;
      butterfly_start <= 1'b0;
    end else begin
      butterfly_start <= 1'b0;
      rd_pend         <= ro_issue;  // RAM answers one cycle later
      if (accept) begin
        smp_cnt <= smp_cnt + 8'd1;
        if (smp_cnt == 8'd0) begin
          len_q <= length;
        end
        if (last_smp) begin
          load_done <= 1'b1;  // Input refused from here on
        end
      end
      if (wr_bfly) begin
        wb_cnt <= wb_cnt + 1'b1;
      end
      case (state)
        bfly_pkg::st_load: begin
          if (row_vld) begin
            ld_cnt <= ld_cnt + 1'b1;
            if (load_done) begin  // Last row being written
              state     <= bfly_pkg::st_compute;
              ld_cnt    <= '0;
              smp_cnt   <= '0;
              load_done <= 1'b0;
            end
          end
        end
        bfly_pkg::st_compute: begin
          rd_cnt <= rd_cnt + 1'b1;  // One row per cycle
          if (cmp_last) begin
            state  <= bfly_pkg::st_drain;
            rd_cnt <= '0;
          end
        end
        bfly_pkg::st_drain: begin
          if (wb_last) begin
            state           <= bfly_pkg::st_readout;
            wb_cnt          <= '0;
            butterfly_start <= 1'b1;
          end
        end
        default: begin  // Readout
          if (ro_issue) begin
            rd_cnt <= rd_cnt + 1'b1;
          end
          if (ro_done) begin
            state  <= bfly_pkg::st_load;
            rd_cnt <= '0;
          end
        end
      endcase
    end
  end

endmodule

// ==== source/bfly_unit.sv ====
`timescale 1ns/1ps

module bfly_unit (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                bfly_go,
  input  logic [bfly_pkg::coef_set_width-1:0] coef_set,  // W4..W1
  input  logic                                in_vld,
  input  logic [bfly_pkg::data_width-1:0]     in_first,
  input  logic [bfly_pkg::data_width-1:0]     in_second,
  output logic                                out_vld,
  output logic [bfly_pkg::data_width-1:0]     out_first,
  output logic [bfly_pkg::data_width-1:0]     out_second
);

  logic signed [bfly_pkg::data_width-1:0]   w_q [4];  // W1..W4
  logic signed [2*bfly_pkg::data_width-1:0] prod_q [bfly_pkg::latency_mul][4];
  logic signed [2*bfly_pkg::data_width:0]   sum1;
  logic signed [2*bfly_pkg::data_width:0]   sum2;
  logic [bfly_pkg::data_width-1:0]          y1_q [bfly_pkg::latency_add];
  logic [bfly_pkg::data_width-1:0]          y2_q [bfly_pkg::latency_add];
  logic [bfly_pkg::bfly_latency-1:0]        vld_q;

  // Coefficients held for the whole pass
  always_ff @(posedge clk) begin
    if (bfly_go) begin
      for (int k = 0; k < 4; k++) begin
        w_q[k] <= coef_set[k*bfly_pkg::data_width +: bfly_pkg::data_width];
      end
    end
  end

  ////////////////////
  // Multiply stages
  ////////////////////
  always_ff @(posedge clk) begin
    prod_q[0][0] <= $signed(in_first) * w_q[0];   // x1*W1 -> y1
    prod_q[0][1] <= $signed(in_first) * w_q[1];   // x1*W2 -> y2
    prod_q[0][2] <= $signed(in_second) * w_q[2];  // x2*W3 -> y1
    prod_q[0][3] <= $signed(in_second) * w_q[3];  // x2*W4 -> y2
    for (int s = 1; s < bfly_pkg::latency_mul; s++) begin
      prod_q[s] <= prod_q[s-1];
    end
  end

  ////////////////////
  // Add, shift, truncate
  ////////////////////
  assign sum1 = prod_q[bfly_pkg::latency_mul-1][0] + prod_q[bfly_pkg::latency_mul-1][2];
  assign sum2 = prod_q[bfly_pkg::latency_mul-1][1] + prod_q[bfly_pkg::latency_mul-1][3];

  always_ff @(posedge clk) begin
    // Arithmetic shift by frac bits, low 16 kept so overflow wraps
    y1_q[0] <= sum1[bfly_pkg::coef_frac_bits +: bfly_pkg::data_width];
    y2_q[0] <= sum2[bfly_pkg::coef_frac_bits +: bfly_pkg::data_width];
    for (int s = 1; s < bfly_pkg::latency_add; s++) begin
      y1_q[s] <= y1_q[s-1];
      y2_q[s] <= y2_q[s-1];
    end
  end

  // Valid rides alongside the data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[bfly_pkg::bfly_latency-2:0], in_vld};
    end
  end

  assign out_vld    = vld_q[bfly_pkg::bfly_latency-1];
  assign out_first  = y1_q[bfly_pkg::latency_add-1];
  assign out_second = y2_q[bfly_pkg::latency_add-1];

endmodule

// ==== verification/bfly_engine_assert.sv ====
`timescale 1ns/1ps

module bfly_engine_assert (
  input logic                            clk,
  input logic                            rst_n,
  input logic                            up_rdy,
  input logic                            butterfly_start,
  input logic                            dn_serial_vld,
  input logic                            dn_serial_rdy,
  input logic [bfly_pkg::data_width-1:0] dn_serial_dat
);

  // Stalled output holds vld and dat
  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    dn_serial_vld && !dn_serial_rdy |=> dn_serial_vld && $stable(dn_serial_dat))
    else $error("serial output changed while stalled");

  a_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    butterfly_start |=> !butterfly_start)  // Single cycle only
    else $error("butterfly_start longer than one cycle");

  // Input closed for the whole readout
  a_rdy_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(up_rdy && dn_serial_vld))
    else $error("up_rdy and dn_serial_vld high together");

endmodule

bind bfly_engine bfly_engine_assert i_assert (
  .clk             (clk),
  .rst_n           (rst_n),
  .up_rdy          (up_rdy),
  .butterfly_start (butterfly_start),
  .dn_serial_vld   (dn_serial_vld),
  .dn_serial_rdy   (dn_serial_rdy),
  .dn_serial_dat   (dn_serial_dat)
);

// ==== verification/tb_bfly_engine.sv ====
`timescale 1ns/1ps

module tb_bfly_engine;

  logic                                clk;
  logic                                rst_n;
  logic [7:0]                          length;
  logic [bfly_pkg::coef_bus_width-1:0] butterfly_coef;
  logic                                up_vld;
  logic [bfly_pkg::data_width-1:0]     up_dat;
  logic                                up_rdy;
  logic                                butterfly_start;
  logic                                dn_serial_vld;
  logic [bfly_pkg::data_width-1:0]     dn_serial_dat;
  logic                                dn_serial_rdy;

  logic [bfly_pkg::data_width-1:0] in_blk  [128];   // Samples sent
  logic [bfly_pkg::data_width-1:0] exp_blk [128];   // Expected readout
  logic [bfly_pkg::data_width-1:0] coef_w  [4][4];  // [unit][W1..W4]
  logic [31:0]                     rng = 32'd29953;
  int                              start_cnt = 0;   // butterfly_start pulses seen

  function automatic int block_cycles(input int len);
    return 3 * len + len / bfly_pkg::num_lanes + 20;  // Load, compute, stalled readout
  endfunction

  bfly_engine i_bfly_engine (
    .clk             (clk),
    .rst_n           (rst_n),
    .length          (length),
    .butterfly_coef  (butterfly_coef),
    .up_vld          (up_vld),
    .up_dat          (up_dat),
    .up_rdy          (up_rdy),
    .butterfly_start (butterfly_start),
    .dn_serial_vld   (dn_serial_vld),
    .dn_serial_dat   (dn_serial_dat),
    .dn_serial_rdy   (dn_serial_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  // Watchdog, four times the expected run length
  initial begin
    int run_cycles;
    run_cycles = 10 + block_cycles(8) + 2 * block_cycles(128) +
                 block_cycles(64) + block_cycles(24);
    repeat (4 * run_cycles) @(posedge clk);
    $display("Timeout: DUT did not finish within %0d cycles", 4 * run_cycles);
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

  always @(negedge clk) begin
    if (butterfly_start) start_cnt++;  // One negedge per pulse
  end

  ////////////////////
  // Helpers
  ////////////////////
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic report_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    $display("test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic fill_random(input int len);
    logic [31:0] r;
    for (int i = 0; i < len; i++) begin
      r = next_rand();
      in_blk[i] = r[15:0];
    end
  endtask

  // Coefficients go on the bus before load and stay until butterfly_start
  task automatic set_coefs(input bit identity);
    logic [31:0] r;
    for (int k = 0; k < bfly_pkg::num_units; k++) begin
      for (int j = 0; j < 4; j++) begin
        r = next_rand();
        if (identity) coef_w[k][j] = (j == 0 || j == 3) ? 16'd16384 : 16'd0;
        else          coef_w[k][j] = r[15:0];
        butterfly_coef[k*bfly_pkg::coef_set_width + j*bfly_pkg::data_width +: 16] =
          coef_w[k][j];
      end
    end
  endtask

  // Reference model
  // y1 = x1*W1 + x2*W3 and y2 = x1*W2 + x2*W4, >>> 14, low 16 bits kept
  task automatic build_expected(input int len);
    int     base;
    int     lane;
    int     k;
    longint x1;
    longint x2;
    longint s;
    for (int i = 0; i < len; i++) begin
      base = (i / bfly_pkg::num_lanes) * bfly_pkg::num_lanes;
      lane = i % bfly_pkg::num_lanes;
      k    = lane / 2;
      x1   = longint'($signed(in_blk[base + 2*k]));
      x2   = longint'($signed(in_blk[base + 2*k + 1]));
      if (lane % 2 == 0) begin
        s = x1 * longint'($signed(coef_w[k][0])) + x2 * longint'($signed(coef_w[k][2]));
      end else begin
        s = x1 * longint'($signed(coef_w[k][1])) + x2 * longint'($signed(coef_w[k][3]));
      end
      s          = s >>> bfly_pkg::coef_frac_bits;
      exp_blk[i] = s[15:0];
    end
  endtask

  // Load, wait for butterfly_start, then collect and compare
  task automatic run_block(input int len, input bit stall, input string name);
    int          idx;
    int          starts_before;
    logic [31:0] r;
    starts_before = start_cnt;
    @(negedge clk);
    length = 8'(len);
    for (int i = 0; i < len; i++) begin
      up_vld = 1'b1;
      up_dat = in_blk[i];
      while (!up_rdy) @(negedge clk);  // Taken on the next posedge
      @(negedge clk);
    end
    up_vld = 1'b0;
    assert (!up_rdy) else report_error($sformatf("%s: up_rdy high after last sample", name));
    while (!butterfly_start) begin
      assert (!dn_serial_vld && !up_rdy)
        else report_error($sformatf("%s: output or input open before butterfly_start", name));
      @(negedge clk);
    end
    idx = 0;
    while (idx < len) begin
      r             = next_rand();
      dn_serial_rdy = stall ? r[0] : 1'b1;
      assert (!up_rdy) else report_error($sformatf("%s: up_rdy high during readout", name));
      if (dn_serial_vld && dn_serial_rdy) begin
        assert (dn_serial_dat === exp_blk[idx])
          else report_error($sformatf("%s: sample %0d got %h expected %h",
                                      name, idx, dn_serial_dat, exp_blk[idx]));
        idx++;
      end
      @(negedge clk);
    end
    dn_serial_rdy = 1'b0;
    assert (up_rdy && !dn_serial_vld)
      else report_error($sformatf("%s: engine not idle after last sample", name));
    assert (start_cnt == starts_before + 1)
      else report_error($sformatf("%s: %0d butterfly_start pulses, expected 1",
                                  name, start_cnt - starts_before));
  endtask

  ////////////////////
  // Tests
  ////////////////////
  task automatic test_reset_values();
    assert (up_rdy && !dn_serial_vld && !butterfly_start)
      else report_error("outputs wrong after reset");
  endtask

  task automatic test_identity();
    set_coefs(1'b1);
    fill_random(8);
    for (int i = 0; i < 8; i++) exp_blk[i] = in_blk[i];  // Pass-through
    run_block(8, 1'b0, "identity");
  endtask

  task automatic test_random_block(input int len, input bit stall, input string name);
    set_coefs(1'b0);  // Separate set per unit
    fill_random(len);
    build_expected(len);
    run_block(len, stall, name);
  endtask

  initial begin
    rst_n          = 1'b0;
    length         = '0;
    butterfly_coef = '0;
    up_vld         = 1'b0;
    up_dat         = '0;
    dn_serial_rdy  = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    test_reset_values();
    test_identity();
    test_random_block(128, 1'b0, "random_128");
    test_random_block(128, 1'b1, "backpressure_128");
    test_random_block(64, 1'b1, "two_blocks_64");
    test_random_block(24, 1'b1, "two_blocks_24");
    repeat (4) @(negedge clk);
    $display("test passed");
    $finish;
  end

endmodule
